// File: sim.f
logic/ann_pkg.sv
logic/node.sv
logic/input_node_timer.sv
logic/neural_to_seven.sv
logic/ann_controller.sv
logic/ann.sv
tests/ann_checker.sv
tests/ann_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the classifier testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module ann_tb -f sim.f -o ann_sim

# the log is kept even when the simulation stops on an error
./obj_dir/ann_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: PASS" sim.log; then
	exit 0
fi
exit 1

// File: tests/ann_tb.sv
////////////////////
// classifier testbench with clock, reset, weight supply,
// layer-by-layer model, watchdog and result assertions
////////////////////
`timescale 1ns/100ps
`default_nettype none

module ann_tb
	import ann_pkg::*;
();

	localparam int image_size = 16;
	localparam int first_layer = 12;
	localparam int second_layer = 8;
	localparam int clk_period = 40;
	localparam int image_count = 24;
	localparam int watchdog_ns = (image_count * 80 + 200) * clk_period;

	logic clk;
	logic n_rst;
	logic image_weights_loaded;
	logic start_detecting;
	logic signed [data_w-1:0] image [image_size-1:0];
	logic signed [data_w-1:0] weights [first_layer-1:0][image_size-1:0];
	logic done_processing;
	logic request_coef;
	logic [1:0] coef_select;
	logic [7:0] seven_seg;
	logic signed [data_w-1:0] pipe_reg [image_size-1:0];

	// one weight set per layer for the image under test
	logic signed [data_w-1:0] layer_w [1:3][first_layer-1:0][image_size-1:0];
	int supply_gap [1:3];
	logic [image_size-1:0][data_w-1:0] exp_pipe;
	logic [image_size-1:0][data_w-1:0] act_pipe;
	logic [7:0] exp_seg;
	logic started;
	string test_name;

	ann ann_inst (
		.clk(clk),
		.n_rst(n_rst),
		.image_weights_loaded(image_weights_loaded),
		.start_detecting(start_detecting),
		.image(image),
		.weights(weights),
		.done_processing(done_processing),
		.request_coef(request_coef),
		.coef_select(coef_select),
		.seven_seg(seven_seg),
		.ANN_pipeline_register(pipe_reg)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	always_comb begin
		for (int i = 0; i < image_size; i++) begin
			act_pipe[i] = pipe_reg[i];
		end
	end

	// segment a on bit 0
	function automatic logic [7:0] seg_pattern(input int digit);
		case (digit)
			0: seg_pattern = 8'h3f;
			1: seg_pattern = 8'h06;
			2: seg_pattern = 8'h5b;
			3: seg_pattern = 8'h4f;
			4: seg_pattern = 8'h66;
			5: seg_pattern = 8'h6d;
			6: seg_pattern = 8'h7d;
			7: seg_pattern = 8'h07;
			8: seg_pattern = 8'h7f;
			default: seg_pattern = 8'h6f;
		endcase
	endfunction

	function automatic logic signed [data_w-1:0] rand_word(input int span);
		rand_word = data_w'(int'($urandom_range(2 * span - 1, 0)) - span);
	endfunction

	// three layers of truncated Q8.8 products, ReLU and clip
	task automatic predict();
		int cur [image_size];
		int nxt [image_size];
		int n_in;
		int n_out;
		int acc;
		int best;
		for (int j = 0; j < image_size; j++) begin
			cur[j] = int'(image[j]);
		end
		for (int l = 1; l <= 3; l++) begin
			n_in = (l == 1) ? image_size : (l == 2) ? first_layer : second_layer;
			n_out = (l == 1) ? first_layer : (l == 2) ? second_layer : digit_count;
			for (int i = 0; i < image_size; i++) begin
				nxt[i] = 0;
			end
			for (int i = 0; i < n_out; i++) begin
				acc = 0;
				for (int j = 0; j < n_in; j++) begin
					acc += (int'(layer_w[l][i][j]) * cur[j]) >>> frac_w;
				end
				nxt[i] = (acc < 0) ? 0 : (acc > 32767) ? 32767 : acc;
			end
			cur = nxt;
		end
		best = 0;
		for (int i = 0; i < image_size; i++) begin
			exp_pipe[i] = data_w'(cur[i]);
			if (i < digit_count && cur[i] > cur[best]) begin
				best = i;
			end
		end
		exp_seg = seg_pattern(best);
	endtask

	task automatic fill_identity();
		for (int l = 1; l <= 3; l++) begin
			for (int i = 0; i < first_layer; i++) begin
				for (int j = 0; j < image_size; j++) begin
					layer_w[l][i][j] = (i == j) ? 16'sh0100 : 16'sh0000;
				end
			end
		end
		for (int j = 0; j < image_size; j++) begin
			image[j] = data_w'(j * 32);
		end
	endtask

	task automatic fill_random(input int span);
		for (int l = 1; l <= 3; l++) begin
			for (int i = 0; i < first_layer; i++) begin
				for (int j = 0; j < image_size; j++) begin
					layer_w[l][i][j] = rand_word(span);
				end
			end
		end
		for (int j = 0; j < image_size; j++) begin
			image[j] = rand_word(span);
		end
	endtask

	task automatic run_image(input string name, input bit extra_start);
		test_name = name;
		predict();
		for (int l = 1; l <= 3; l++) begin
			supply_gap[l] = int'($urandom_range(5, 0));
		end
		started = 1'b1;
		start_detecting = 1'b1;
		@(posedge clk);
		#2 start_detecting = 1'b0;
		if (extra_start) begin
			// lands while the first image is still in flight
			repeat (3) @(posedge clk);
			#2 start_detecting = 1'b1;
			@(posedge clk);
			#2 start_detecting = 1'b0;
		end
		while (!done_processing) begin
			@(posedge clk);
			#2;
		end
		repeat (4) @(posedge clk);
		#2;
	endtask

	// answers each request with the stored weights of that layer
	initial begin : weight_supply
		int sel;
		forever begin
			@(posedge clk);
			#2;
			if (request_coef) begin
				sel = int'(coef_select);
				for (int i = 0; i < first_layer; i++) begin
					for (int j = 0; j < image_size; j++) begin
						weights[i][j] = layer_w[sel][i][j];
					end
				end
				// one cycle to reach wait_loaded and then the random delay
				repeat (supply_gap[sel] + 1) @(posedge clk);
				#2 image_weights_loaded = 1'b1;
				@(posedge clk);
				#2 image_weights_loaded = 1'b0;
			end
		end
	end

	initial begin : stimulus
		void'($urandom(32'h378c));
		n_rst = 1'b0;
		start_detecting = 1'b0;
		image_weights_loaded = 1'b0;
		started = 1'b0;
		test_name = "reset";
		exp_pipe = '0;
		exp_seg = 8'h00;
		for (int i = 0; i < first_layer; i++) begin
			for (int j = 0; j < image_size; j++) begin
				weights[i][j] = 16'sh0000;
			end
		end
		for (int j = 0; j < image_size; j++) begin
			image[j] = 16'sh0000;
		end
		repeat (8) @(posedge clk);
		#2 n_rst = 1'b1;
		repeat (4) @(posedge clk);
		#2;
		fill_identity();
		image[5] = 16'sh0a00;
		run_image("identity_dominant", 1'b0);
		// equal top scores at 2 and 7 and a negative sample clipped by ReLU
		fill_identity();
		image[2] = 16'sh0600;
		image[7] = 16'sh0600;
		image[4] = -16'sh0300;
		run_image("identity_tie", 1'b0);
		fill_identity();
		layer_w[3][9][0] = 16'sh0400;
		image[0] = 16'sh0200;
		run_image("identity_row9", 1'b0);
		fill_identity();
		image[3] = 16'sh0800;
		run_image("busy_start", 1'b1);
		for (int n = 0; n < 20; n++) begin
			fill_random((n % 3 == 0) ? 32768 : (n % 3 == 1) ? 4096 : 256);
			run_image($sformatf("random_%0d", n), 1'b0);
		end
		$display("Simulation finished: PASS");
		$finish;
	end

	initial begin : watchdog
		#(watchdog_ns);
		$display("timeout: the run did not complete within %0d ns", watchdog_ns);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped by the watchdog");
	end

	reset_state: assert property (@(posedge clk) disable iff (!n_rst)
		!started |-> act_pipe == '0 && !request_coef && !done_processing)
		else begin
			$display("error: reset_state expected pipeline 0 actual %h (request %b, done %b)",
				act_pipe, request_coef, done_processing);
			$display("Simulation finished: FAIL");
			$fatal(1, "outputs not idle after reset");
		end

	pipe_result: assert property (@(posedge clk) disable iff (!n_rst)
		done_processing |-> act_pipe == exp_pipe)
		else begin
			$display("error: %s pipeline expected %h actual %h", test_name, exp_pipe, act_pipe);
			$display("Simulation finished: FAIL");
			$fatal(1, "pipeline contents differ from the model");
		end

	digit_result: assert property (@(posedge clk) disable iff (!n_rst)
		done_processing |-> seven_seg == exp_seg)
		else begin
			$display("error: %s seven_seg expected %h actual %h", test_name, exp_seg, seven_seg);
			$display("Simulation finished: FAIL");
			$fatal(1, "digit pattern differs from the model");
		end

endmodule

`default_nettype wire

// File: tests/ann_checker.sv
////////////////////
// control assertions bound to the classifier top level
////////////////////
`timescale 1ns/100ps
`default_nettype none

module ann_checker
	import ann_pkg::*;
(
	input logic clk,
	input logic n_rst,
	input logic start_detecting,
	input logic request_coef,
	input logic [1:0] coef_select,
	input logic done_processing,
	input load_sel_t load_next
);

	logic busy;
	logic seen_start;
	logic req_d;
	logic [1:0] req_count;

	// mirrors which start was accepted and how many layers were requested
	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			busy <= 1'b0;
			seen_start <= 1'b0;
			req_d <= 1'b0;
			req_count <= 2'd0;
		end else begin
			req_d <= request_coef;
			if (start_detecting && !busy) begin
				busy <= 1'b1;
				seen_start <= 1'b1;
				req_count <= 2'd0;
			end else if (done_processing) begin
				busy <= 1'b0;
			end
			if (request_coef && !req_d) begin
				req_count <= req_count + 2'd1;
			end
		end
	end

	assert property (@(posedge clk) disable iff (!n_rst)
		!seen_start |-> !request_coef && !done_processing)
		else $error("control outputs active before the first start");

	assert property (@(posedge clk) disable iff (!n_rst)
		request_coef && !req_d |-> coef_select == req_count + 2'd1)
		else $error("layers not requested in the order 1, 2, 3");

	assert property (@(posedge clk) disable iff (!n_rst)
		request_coef |=> !request_coef || $stable(coef_select))
		else $error("coef_select changed during a weight request");

	assert property (@(posedge clk) disable iff (!n_rst)
		done_processing |=> !done_processing)
		else $error("done_processing longer than one cycle");

	assert property (@(posedge clk) disable iff (!n_rst)
		done_processing |-> busy && req_count == 2'd3)
		else $error("done_processing without a matching start and three layers");

	assert property (@(posedge clk) disable iff (!n_rst)
		start_detecting && !busy |=> load_next == image)
		else $error("accepted start did not load the image");

endmodule

bind ann ann_checker checker_inst (
	.clk(clk),
	.n_rst(n_rst),
	.start_detecting(start_detecting),
	.request_coef(request_coef),
	.coef_select(coef_select),
	.done_processing(done_processing),
	.load_next(load_next)
);

`default_nettype wire

// File: logic/ann.sv
////////////////////
// classifier top level with pipeline register, node bank,
// registered node outputs, timer, controller, digit decoder
////////////////////
`timescale 1ns/100ps
`default_nettype none

module ann
	import ann_pkg::*;
#(
	parameter int IMAGE_SIZE = 16,
	parameter int FIRST_LAYER = 12,
	parameter int SECOND_LAYER = 8,
	parameter int THIRD_LAYER = 10
)
(
	input logic clk,
	input logic n_rst,
	input logic image_weights_loaded,
	input logic start_detecting,
	input logic signed [data_w-1:0] image [IMAGE_SIZE-1:0],
	input logic signed [data_w-1:0] weights [FIRST_LAYER-1:0][IMAGE_SIZE-1:0],
	output logic done_processing,
	output logic request_coef,
	output logic [1:0] coef_select,
	output logic [7:0] seven_seg,
	output logic signed [data_w-1:0] ANN_pipeline_register [IMAGE_SIZE-1:0]
);

	logic [idx_w-1:0] max_input;
	logic [idx_w-1:0] input_num;
	logic sweep_start;
	logic coef_ready;
	logic n_start_done;
	logic reset_accum;
	logic done_next;
	load_sel_t load_next;

	logic signed [data_w-1:0] node_result [FIRST_LAYER-1:0];
	logic signed [data_w-1:0] node_out [FIRST_LAYER-1:0];
	logic signed [data_w-1:0] pipe_next [IMAGE_SIZE-1:0];
	logic signed [data_w-1:0] scores [digit_count-1:0];

	// one node per first-layer neuron and later layers reuse the low ones
	for (genvar i = 0; i < FIRST_LAYER; i++) begin : g_node
		node #(.IMAGE_SIZE(IMAGE_SIZE)) node_inst (
			.clk(clk),
			.n_rst(n_rst),
			.n_start_done(n_start_done),
			.reset_acc(reset_accum),
			.cnt_val(input_num),
			.coef(weights[i]),
			.data_in(ANN_pipeline_register),
			.node_out(node_result[i])
		);
	end

	input_node_timer timer_inst (
		.clk(clk),
		.n_rst(n_rst),
		.sweep_start(sweep_start),
		.max_input(max_input),
		.input_num(input_num),
		.n_start_done(n_start_done),
		.coef_ready(coef_ready)
	);

	ann_controller #(
		.IMAGE_SIZE(IMAGE_SIZE),
		.FIRST_LAYER(FIRST_LAYER),
		.SECOND_LAYER(SECOND_LAYER),
		.THIRD_LAYER(THIRD_LAYER)
	) controller_inst (
		.clk(clk),
		.n_rst(n_rst),
		.image_weights_loaded(image_weights_loaded),
		.start_detecting(start_detecting),
		.coef_ready(coef_ready),
		.n_start_done(n_start_done),
		.max_input(max_input),
		.sweep_start(sweep_start),
		.reset_accum(reset_accum),
		.request_coef(request_coef),
		.load_next(load_next),
		.coef_select(coef_select),
		.done_processing(done_next)
	);

	// the final scores sit in the low words of the pipeline
	always_comb begin
		for (int i = 0; i < digit_count; i++) begin
			scores[i] = ANN_pipeline_register[i];
		end
	end

	neural_to_seven decoder_inst (
		.neural_out(scores),
		.seven_seg(seven_seg)
	);

	// write-back of the image or the first N node results with zero fill
	always_comb begin
		int fill;
		fill = 0;
		pipe_next = ANN_pipeline_register;
		case (load_next)
			layer_1: fill = FIRST_LAYER;
			layer_2: fill = SECOND_LAYER;
			layer_3: fill = THIRD_LAYER;
			default: fill = 0;
		endcase
		if (load_next == ann_pkg::image) begin
			pipe_next = image;
		end else if (load_next != hold) begin
			for (int i = 0; i < IMAGE_SIZE; i++) begin
				pipe_next[i] = '0;
			end
			for (int i = 0; i < FIRST_LAYER; i++) begin
				if (i < fill) begin
					pipe_next[i] = node_out[i];
				end
			end
		end
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			for (int i = 0; i < IMAGE_SIZE; i++) begin
				ANN_pipeline_register[i] <= '0;
			end
			done_processing <= 1'b0;
		end else begin
			ANN_pipeline_register <= pipe_next;
			done_processing <= done_next;
		end
	end

	// node results captured one cycle after they settle
	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			for (int i = 0; i < FIRST_LAYER; i++) begin
				node_out[i] <= '0;
			end
		end else begin
			node_out <= node_result;
		end
	end

endmodule

`default_nettype wire

// File: logic/ann_controller.sv
////////////////////
// layer sequencer for image load, weight requests,
// input sweeps and write-back selection
////////////////////
`timescale 1ns/100ps
`default_nettype none

module ann_controller
	import ann_pkg::*;
#(
	parameter int IMAGE_SIZE = 16,
	parameter int FIRST_LAYER = 12,
	parameter int SECOND_LAYER = 8,
	parameter int THIRD_LAYER = 10
)
(
	input logic clk,
	input logic n_rst,
	input logic image_weights_loaded,
	input logic start_detecting,
	input logic coef_ready,
	input logic n_start_done,
	output logic [idx_w-1:0] max_input,
	output logic sweep_start,
	output logic reset_accum,
	output logic request_coef,
	output load_sel_t load_next,
	output logic [1:0] coef_select,
	output logic done_processing
);

	ctrl_state_t state;
	ctrl_state_t next_state;
	logic [1:0] layer;
	logic [1:0] next_layer;

	// the node bank is sized by layer 1 and the pipeline by the image
	if (SECOND_LAYER > FIRST_LAYER || THIRD_LAYER > FIRST_LAYER ||
			FIRST_LAYER > IMAGE_SIZE) begin : g_size_check
		$error("layer sizes do not fit the node bank or the pipeline register");
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			state <= idle;
			layer <= 2'd1;
		end else begin
			state <= next_state;
			layer <= next_layer;
		end
	end

	// each sweep covers the width of the previous layer
	always_comb begin
		case (layer)
			2'd2: max_input = idx_w'(FIRST_LAYER);
			2'd3: max_input = idx_w'(SECOND_LAYER);
			default: max_input = idx_w'(IMAGE_SIZE);
		endcase
	end

	assign coef_select = layer;

	always_comb begin
		next_state = state;
		next_layer = layer;
		sweep_start = 1'b0;
		reset_accum = 1'b0;
		request_coef = 1'b0;
		load_next = hold;
		done_processing = 1'b0;
		case (state)
			idle: begin
				if (start_detecting) begin
					next_state = load_image;
					next_layer = 2'd1;
				end
			end
			load_image: begin
				load_next = image;
				next_state = request;
			end
			request: begin
				request_coef = 1'b1;
				next_state = wait_loaded;
			end
			wait_loaded: begin
				request_coef = 1'b1;
				// clear the nodes and start the sweep once the weights are stable
				if (image_weights_loaded) begin
					sweep_start = 1'b1;
					reset_accum = 1'b1;
					next_state = sweep;
				end
			end
			sweep: begin
				if (coef_ready && n_start_done) begin
					next_state = settle;
				end
			end
			settle: begin
				next_state = write_back;
			end
			write_back: begin
				case (layer)
					2'd1: load_next = layer_1;
					2'd2: load_next = layer_2;
					default: load_next = layer_3;
				endcase
				if (layer == 2'd3) begin
					done_processing = 1'b1;
					next_state = finish;
				end else begin
					next_layer = layer + 2'd1;
					next_state = request;
				end
			end
			finish: begin
				next_state = idle;
			end
			default: begin
				next_state = idle;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: logic/neural_to_seven.sv
////////////////////
// arg-max over the digit scores, seven-segment encoding
////////////////////
`timescale 1ns/100ps
`default_nettype none

module neural_to_seven
	import ann_pkg::*;
(
	input logic signed [data_w-1:0] neural_out [digit_count-1:0],
	output logic [7:0] seven_seg
);

	logic [3:0] best_idx;
	logic signed [data_w-1:0] best_val;

	// strict compare keeps the lower index on a tie
	always_comb begin
		best_idx = 4'd0;
		best_val = neural_out[0];
		for (int i = 1; i < digit_count; i++) begin
			if (neural_out[i] > best_val) begin
				best_val = neural_out[i];
				best_idx = 4'(i);
			end
		end
	end

	// segment a on bit 0, dot on bit 7 never lit
	always_comb begin
		case (best_idx)
			4'd0: seven_seg = 8'h3f;
			4'd1: seven_seg = 8'h06;
			4'd2: seven_seg = 8'h5b;
			4'd3: seven_seg = 8'h4f;
			4'd4: seven_seg = 8'h66;
			4'd5: seven_seg = 8'h6d;
			4'd6: seven_seg = 8'h7d;
			4'd7: seven_seg = 8'h07;
			4'd8: seven_seg = 8'h7f;
			4'd9: seven_seg = 8'h6f;
			default: seven_seg = 8'h00;
		endcase
	end

endmodule

`default_nettype wire

// File: logic/input_node_timer.sv
////////////////////
// input index sweep for one layer
////////////////////
`timescale 1ns/100ps
`default_nettype none

module input_node_timer
	import ann_pkg::*;
(
	input logic clk,
	input logic n_rst,
	input logic sweep_start,
	input logic [idx_w-1:0] max_input,
	output logic [idx_w-1:0] input_num,
	output logic n_start_done,
	output logic coef_ready
);

	logic active;
	logic [idx_w-1:0] count;
	logic [idx_w-1:0] limit;

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			active <= 1'b0;
			count <= '0;
			limit <= '0;
			coef_ready <= 1'b0;
		end else begin
			coef_ready <= 1'b0;
			if (sweep_start) begin
				// limit held for the whole sweep
				active <= 1'b1;
				count <= '0;
				limit <= max_input;
			end else if (active) begin
				if (count == limit - 1'b1) begin
					active <= 1'b0;
					count <= '0;
					coef_ready <= 1'b1;
				end else begin
					count <= count + 1'b1;
				end
			end
		end
	end

	assign input_num = count;
	assign n_start_done = !active;

endmodule

`default_nettype wire

// File: logic/node.sv
////////////////////
// saturating Q8.8 multiply-accumulate neuron, ReLU output
////////////////////
`timescale 1ns/100ps
`default_nettype none

module node
	import ann_pkg::*;
#(
	parameter int IMAGE_SIZE = 16
)
(
	input logic clk,
	input logic n_rst,
	input logic n_start_done,
	input logic reset_acc,
	input logic [idx_w-1:0] cnt_val,
	input logic signed [data_w-1:0] coef [IMAGE_SIZE-1:0],
	input logic signed [data_w-1:0] data_in [IMAGE_SIZE-1:0],
	output logic signed [data_w-1:0] node_out
);

	localparam int acc_w = 2 * data_w;
	localparam int sel_w = (IMAGE_SIZE > 1) ? $clog2(IMAGE_SIZE) : 1;

	logic [sel_w-1:0] sel;
	logic signed [2*data_w-1:0] product;
	logic signed [acc_w-1:0] acc;

	assign sel = sel_w'(cnt_val);
	assign product = coef[sel] * data_in[sel];

	// product brought back to Q8.8 before it is summed
	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			acc <= '0;
		end else if (reset_acc) begin
			acc <= '0;
		end else if (!n_start_done) begin
			acc <= acc + (product >>> frac_w);
		end
	end

	always_comb begin
		if (acc[acc_w-1]) begin
			node_out = '0;
		end else if (|acc[acc_w-2:data_w-1]) begin
			node_out = {1'b0, {(data_w-1){1'b1}}};
		end else begin
			node_out = acc[data_w-1:0];
		end
	end

endmodule

`default_nettype wire

// File: logic/ann_pkg.sv
////////////////////
// shared data widths, index width and score count
// controller state and write-back select enums
////////////////////
`default_nettype none

package ann_pkg;

	// signed Q8.8 for samples, weights and scores
	localparam int data_w = 16;
	localparam int frac_w = 8;

	// input index wide enough for images up to 64 samples
	localparam int idx_w = 7;

	// one score per digit out of the last layer
	localparam int digit_count = 10;

	typedef enum logic [2:0] {
		idle, load_image, request, wait_loaded, sweep, settle, write_back, finish
	} ctrl_state_t;

	// what the pipeline register takes on the next edge
	typedef enum logic [2:0] {
		hold, layer_1, layer_2, layer_3, image
	} load_sel_t;

endpackage

`default_nettype wire
